//--- rtl/video_pkg.sv
// ##########################################################
// shared types, register numbers and default 640x480 timing
// visible pixels sit at the end of each line, after blanking
// ##########################################################
`default_nettype none

package video_pkg;

    typedef logic [15:0]    word_t;                 // register and vram data
    typedef logic [15:0]    addr_t;                 // vram word address
    typedef logic [7:0]     color_t;                // palette index
    typedef logic [9:0]     hres_t;                 // horizontal count
    typedef logic [9:0]     vres_t;                 // vertical count

    // one display word, seen either as bytes or as nibbles
    typedef union packed {
        logic [1:0][7:0]    px8;                    // [1] is shown first
        logic [3:0][3:0]    px4;                    // [3] is shown first
    } disp_word_u;

    localparam logic [4:0] XR_VID_CTRL      = 5'h00;    // border colour in [15:8]
    localparam logic [4:0] XR_SCANLINE      = 5'h02;    // read only
    localparam logic [4:0] XR_VID_HSIZE     = 5'h04;    // read only
    localparam logic [4:0] XR_VID_VSIZE     = 5'h05;    // read only
    localparam logic [4:0] XR_PA_GFX_CTRL   = 5'h10;    // colourbase, blank, bpp8
    localparam logic [4:0] XR_PA_DISP_ADDR  = 5'h12;
    localparam logic [4:0] XR_PA_LINE_LEN   = 5'h13;

    localparam int DEF_H_VISIBLE    = 640;
    localparam int DEF_H_TOTAL      = 800;
    localparam int DEF_H_SYNC_START = 16;           // after front porch
    localparam int DEF_H_SYNC_END   = 112;
    localparam int DEF_V_VISIBLE    = 480;
    localparam int DEF_V_TOTAL      = 525;
    localparam int DEF_V_SYNC_START = 490;
    localparam int DEF_V_SYNC_END   = 492;

    // cycles from start of line fetch to first visible pixel
    localparam int FETCH_LEAD       = 8;

endpackage

`default_nettype wire

//--- rtl/video_timing.sv
// ##########################################################
// counters for line and frame, all flags decoded from them
// needs H_TOTAL >= H_VISIBLE + FETCH_LEAD + 2
// ##########################################################
`default_nettype none

module video_timing #(
    parameter int H_VISIBLE,
    parameter int H_TOTAL,
    parameter int H_SYNC_START,
    parameter int H_SYNC_END,
    parameter int V_VISIBLE,
    parameter int V_TOTAL,
    parameter int V_SYNC_START,
    parameter int V_SYNC_END
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output video_pkg::hres_t    h_count_o,
    output video_pkg::vres_t    v_count_o,
    output logic                v_visible_o,
    output logic                visible_o,
    output logic                end_of_line_o,
    output logic                end_of_frame_o,
    output logic                fetch_start_o,
    output logic                hsync_o,
    output logic                vsync_o
);
    import video_pkg::*;

    localparam int H_VIS_START  = H_TOTAL - H_VISIBLE;     // first visible column
    localparam int H_FETCH      = H_VIS_START - FETCH_LEAD;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o   <= '0;
            v_count_o   <= '0;
        end else if (end_of_line_o) begin
            h_count_o   <= '0;
            if (end_of_frame_o) begin
                v_count_o   <= '0;
            end else begin
                v_count_o   <= v_count_o + 1'b1;
            end
        end else begin
            h_count_o   <= h_count_o + 1'b1;
        end
    end

    assign end_of_line_o    = (h_count_o == hres_t'(H_TOTAL - 1));
    assign end_of_frame_o   = end_of_line_o && (v_count_o == vres_t'(V_TOTAL - 1));
    assign v_visible_o      = (v_count_o < vres_t'(V_VISIBLE));
    assign visible_o        = v_visible_o && (h_count_o >= hres_t'(H_VIS_START));
    assign fetch_start_o    = v_visible_o && (h_count_o == hres_t'(H_FETCH));
    assign hsync_o          = (h_count_o >= hres_t'(H_SYNC_START)) &&
                              (h_count_o < hres_t'(H_SYNC_END));
    assign vsync_o          = (v_count_o >= vres_t'(V_SYNC_START)) &&
                              (v_count_o < vres_t'(V_SYNC_END));

    // frame end closes a line, and that last line lies in vertical blanking
    a_frame_end: assert property (@(posedge clk) disable iff (reset_i)
        end_of_frame_o |-> end_of_line_o && !v_visible_o)
        else $error("frame end on a visible line or without line end");

endmodule

`default_nettype wire

//--- rtl/video_regs.sv
// ##########################################################
// host configuration registers, readback one cycle late
// unlisted register numbers read as zero
// ##########################################################
`default_nettype none

module video_regs #(
    parameter int H_VISIBLE,
    parameter int V_VISIBLE
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_en_i,
    input  wire logic [4:0]         reg_num_i,
    input  wire video_pkg::word_t   reg_data_i,
    output video_pkg::word_t        reg_data_o,
    input  wire video_pkg::vres_t   v_count_i,
    input  wire logic               v_visible_i,
    output video_pkg::color_t       border_color_o,
    output video_pkg::color_t       colorbase_o,
    output logic                    blank_o,
    output logic                    bpp8_o,
    output video_pkg::addr_t        disp_addr_o,
    output video_pkg::word_t        line_len_o
);
    import video_pkg::*;

    word_t  rd_data;                                // selected register, before the flop

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color_o  <= 8'h08;               // dark grey shows the output is alive
            colorbase_o     <= 8'h00;
            blank_o         <= 1'b1;
            bpp8_o          <= 1'b0;
            disp_addr_o     <= '0;
            line_len_o      <= word_t'(H_VISIBLE / 4);
        end else if (reg_wr_en_i) begin
            case (reg_num_i)
                XR_VID_CTRL: begin
                    border_color_o  <= reg_data_i[15:8];
                end
                XR_PA_GFX_CTRL: begin
                    colorbase_o     <= reg_data_i[15:8];
                    blank_o         <= reg_data_i[7];
                    bpp8_o          <= reg_data_i[4];
                end
                XR_PA_DISP_ADDR: begin
                    disp_addr_o     <= reg_data_i;
                end
                XR_PA_LINE_LEN: begin
                    line_len_o      <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (reg_num_i)
            XR_VID_CTRL:        rd_data = {border_color_o, 8'h00};
            XR_SCANLINE:        rd_data = {~v_visible_i, 5'b00000, v_count_i};
            XR_VID_HSIZE:       rd_data = word_t'(H_VISIBLE);
            XR_VID_VSIZE:       rd_data = word_t'(V_VISIBLE);
            XR_PA_GFX_CTRL:     rd_data = {colorbase_o, blank_o, 2'b00, bpp8_o, 4'h0};
            XR_PA_DISP_ADDR:    rd_data = disp_addr_o;
            XR_PA_LINE_LEN:     rd_data = line_len_o;
            default:            rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o  <= rd_data;
    end

endmodule

`default_nettype wire

//--- rtl/pixel_fetch.sv
// ##########################################################
// reads one line of display words from vram per visible line
// vram data must return exactly one cycle after the select
// ##########################################################
`default_nettype none

module pixel_fetch #(
    parameter int H_VISIBLE
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               fetch_start_i,
    input  wire logic               end_of_line_i,
    input  wire logic               end_of_frame_i,
    input  wire logic               v_visible_i,
    input  wire logic               bpp8_i,
    input  wire video_pkg::addr_t   disp_addr_i,
    input  wire video_pkg::word_t   line_len_i,
    output logic                    vram_sel_o,
    output video_pkg::addr_t        vram_addr_o,
    input  wire video_pkg::word_t   vram_data_i,
    output logic                    word_valid_o,
    output video_pkg::word_t        word_data_o,
    input  wire logic               word_ready_i
);
    import video_pkg::*;

    localparam int WORDS_W = $clog2(H_VISIBLE / 2 + 1);
    localparam logic [WORDS_W-1:0] WORDS_4BPP = WORDS_W'(H_VISIBLE / 4);
    localparam logic [WORDS_W-1:0] WORDS_8BPP = WORDS_W'(H_VISIBLE / 2);

    addr_t                  line_base;              // first word of current line
    word_t                  line_len;               // stride, taken once per frame
    logic [WORDS_W-1:0]     words_left;             // reads still to issue this line
    logic                   rd_pending;             // data arrives this cycle
    logic                   transfer;

    assign transfer     = word_valid_o && word_ready_i;
    // only one word in flight, and only if the buffer is sure to be free
    assign vram_sel_o   = (words_left != '0) && !rd_pending && (!word_valid_o || transfer);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_base       <= '0;
            line_len        <= word_t'(H_VISIBLE / 4);
            words_left      <= '0;
            vram_addr_o     <= '0;
            rd_pending      <= 1'b0;
            word_valid_o    <= 1'b0;
        end else begin
            if (end_of_frame_i) begin
                line_base   <= disp_addr_i;
                line_len    <= line_len_i;
            end else if (end_of_line_i && v_visible_i) begin
                line_base   <= line_base + line_len;
            end
            if (fetch_start_i) begin
                words_left  <= bpp8_i ? WORDS_8BPP : WORDS_4BPP;
                vram_addr_o <= line_base;
            end else if (vram_sel_o) begin
                words_left  <= words_left - 1'b1;
                vram_addr_o <= vram_addr_o + 1'b1;
            end
            rd_pending      <= vram_sel_o;
            if (rd_pending) begin
                word_valid_o    <= 1'b1;
            end else if (transfer) begin
                word_valid_o    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            word_data_o <= vram_data_i;             // holding buffer
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |=> (!word_valid_o || word_ready_i))
        else $error("vram word returned into a full buffer");

endmodule

`default_nettype wire

//--- rtl/pixel_shifter.sv
// ##########################################################
// shifts display words out as colour indices, 4 or 8 bpp
// all video outputs are registered and aligned
// ##########################################################
`default_nettype none

module pixel_shifter (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               visible_i,
    input  wire logic               hsync_i,
    input  wire logic               vsync_i,
    input  wire logic               blank_i,
    input  wire logic               bpp8_i,
    input  wire video_pkg::color_t  colorbase_i,
    input  wire video_pkg::color_t  border_color_i,
    input  wire logic               word_valid_i,
    input  wire video_pkg::word_t   word_data_i,
    output logic                    word_ready_o,
    output video_pkg::color_t       color_index_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);
    import video_pkg::*;

    disp_word_u     cur_word;
    logic [2:0]     px_left;                        // pixels still in cur_word
    logic           shift_en;                       // showing playfield data
    logic           load;
    color_t         pixel;

    assign shift_en     = visible_i && !blank_i;
    assign word_ready_o = (px_left == 3'd0) || (shift_en && px_left == 3'd1);
    assign load         = word_valid_i && word_ready_o;
    assign pixel        = bpp8_i ? cur_word.px8[1] : {4'h0, cur_word.px4[3]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            px_left         <= '0;
            color_index_o   <= '0;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
            dv_de_o         <= 1'b0;
        end else begin
            if (load) begin
                px_left     <= bpp8_i ? 3'd2 : 3'd4;
            end else if (shift_en && px_left != 3'd0) begin
                px_left     <= px_left - 1'b1;
            end
            hsync_o         <= hsync_i;
            vsync_o         <= vsync_i;
            dv_de_o         <= visible_i;
            if (!visible_i) begin
                color_index_o   <= '0;
            end else if (blank_i) begin
                color_index_o   <= border_color_i;
            end else begin
                color_index_o   <= pixel ^ colorbase_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cur_word    <= word_data_i;
        end else if (shift_en) begin
            if (bpp8_i) begin
                cur_word.px8    <= {cur_word.px8[0], 8'h00};
            end else begin
                cur_word.px4    <= {cur_word.px4[2:0], 4'h0};
            end
        end
    end

    // fetch must keep up with the display
    a_no_underrun: assert property (@(posedge clk) disable iff (reset_i)
        shift_en |-> (px_left != 3'd0))
        else $error("shifter empty on a visible pixel");

endmodule

`default_nettype wire

//--- rtl/video_gen.sv
// ##########################################################
// bitmap video generator, one playfield
// timing parameters are set here and passed to every stage
// ##########################################################
`default_nettype none

module video_gen #(
    parameter int H_VISIBLE     = video_pkg::DEF_H_VISIBLE,
    parameter int H_TOTAL       = video_pkg::DEF_H_TOTAL,
    parameter int H_SYNC_START  = video_pkg::DEF_H_SYNC_START,
    parameter int H_SYNC_END    = video_pkg::DEF_H_SYNC_END,
    parameter int V_VISIBLE     = video_pkg::DEF_V_VISIBLE,
    parameter int V_TOTAL       = video_pkg::DEF_V_TOTAL,
    parameter int V_SYNC_START  = video_pkg::DEF_V_SYNC_START,
    parameter int V_SYNC_END    = video_pkg::DEF_V_SYNC_END
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               reg_wr_en_i,
    input  wire logic [4:0]         reg_num_i,
    input  wire video_pkg::word_t   reg_data_i,
    output video_pkg::word_t        reg_data_o,
    output logic                    vram_sel_o,
    output video_pkg::addr_t        vram_addr_o,
    input  wire video_pkg::word_t   vram_data_i,
    output video_pkg::color_t       color_index_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);
    import video_pkg::*;

    vres_t  v_count;
    logic   v_visible, visible, end_of_line, end_of_frame, fetch_start;
    logic   hsync, vsync;
    color_t border_color, colorbase;
    logic   blank, bpp8;
    addr_t  disp_addr;
    word_t  line_len;
    logic   word_valid, word_ready;
    word_t  word_data;

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
        .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
    ) u_timing (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(),                               // no horizontal position user here
        .v_count_o(v_count), .v_visible_o(v_visible), .visible_o(visible),
        .end_of_line_o(end_of_line), .end_of_frame_o(end_of_frame),
        .fetch_start_o(fetch_start), .hsync_o(hsync), .vsync_o(vsync)
    );

    video_regs #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) u_regs (
        .clk(clk), .reset_i(reset_i), .reg_wr_en_i(reg_wr_en_i),
        .reg_num_i(reg_num_i), .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .v_count_i(v_count), .v_visible_i(v_visible),
        .border_color_o(border_color), .colorbase_o(colorbase),
        .blank_o(blank), .bpp8_o(bpp8), .disp_addr_o(disp_addr), .line_len_o(line_len)
    );

    pixel_fetch #(.H_VISIBLE(H_VISIBLE)) u_fetch (
        .clk(clk), .reset_i(reset_i),
        .fetch_start_i(fetch_start & ~blank),       // blanked playfield reads no vram
        .end_of_line_i(end_of_line), .end_of_frame_i(end_of_frame),
        .v_visible_i(v_visible), .bpp8_i(bpp8),
        .disp_addr_i(disp_addr), .line_len_i(line_len),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .word_valid_o(word_valid), .word_data_o(word_data), .word_ready_i(word_ready)
    );

    pixel_shifter u_shifter (
        .clk(clk), .reset_i(reset_i),
        .visible_i(visible), .hsync_i(hsync), .vsync_i(vsync),
        .blank_i(blank), .bpp8_i(bpp8),
        .colorbase_i(colorbase), .border_color_i(border_color),
        .word_valid_i(word_valid), .word_data_i(word_data), .word_ready_o(word_ready),
        .color_index_o(color_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_video_gen.sv
// ############################################################
// testbench for video_gen with a 16x4 visible area
// vram image and per-frame setups come from tb/video_patterns.hex
// must be run from the project root
// ############################################################
`default_nettype none

module tb_video_gen;
    import video_pkg::*;

    localparam int H_VISIBLE    = 16;
    localparam int H_TOTAL      = 32;
    localparam int H_SYNC_START = 2;
    localparam int H_SYNC_END   = 6;
    localparam int V_VISIBLE    = 4;
    localparam int V_TOTAL      = 6;
    localparam int V_SYNC_START = 4;
    localparam int V_SYNC_END   = 5;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int VRAM_WORDS   = 64;
    localparam int NUM_TRIPLES  = 4;
    localparam int PAT_WORDS    = VRAM_WORDS + 3 * NUM_TRIPLES;
    localparam int NUM_FRAMES   = NUM_TRIPLES + 1;     // reset frame plus one per triple
    localparam int TIMEOUT      = (NUM_FRAMES + 1) * V_TOTAL * H_TOTAL * CLK_PERIOD
                                  + 50 * CLK_PERIOD;

    logic           clk;
    logic           reset_i;
    logic           reg_wr_en_i;
    logic [4:0]     reg_num_i;
    word_t          reg_data_i;
    word_t          reg_data_o;
    logic           vram_sel_o;
    addr_t          vram_addr_o;
    word_t          vram_data_i;
    color_t         color_index_o;
    logic           hsync_o;
    logic           vsync_o;
    logic           dv_de_o;

    word_t          pattern [0:PAT_WORDS-1];        // vram image, then triples
    word_t          cfg_gfx [0:NUM_FRAMES];         // setup in force per frame
    addr_t          cfg_addr [0:NUM_FRAMES];
    word_t          cfg_len [0:NUM_FRAMES];
    color_t         cfg_border [0:NUM_FRAMES];
    logic [16:0]    lfsr_state;

    int             fr;                             // frames closed by a vsync rise
    int             line_cnt;
    int             px_cnt;
    int             rd_cnt;                         // vram reads seen on this line
    int             hs_cnt;
    int             vs_len;
    int             cyc_cnt;
    int             sel_cnt;
    logic           prev_de;
    logic           prev_hs;
    logic           prev_vs;

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
        .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
    ) u_dut (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .color_index_o(color_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // vram answers one cycle after the select
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= pattern[vram_addr_o[5:0]];
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [16:0] next_lfsr(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};    // taps 17 and 14
    endfunction

    task automatic take_random(input int nbits, output word_t value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            value      = {value[14:0], lfsr_state[0]};
        end
    endtask

    function automatic logic is_mapped(input logic [4:0] num);
        case (num)
            XR_VID_CTRL, XR_SCANLINE, XR_VID_HSIZE, XR_VID_VSIZE,
            XR_PA_GFX_CTRL, XR_PA_DISP_ADDR, XR_PA_LINE_LEN: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // vram address of word idx on visible line y
    function automatic addr_t line_word_addr(input int frame, input int y, input int idx);
        return cfg_addr[frame] + addr_t'(y) * cfg_len[frame] + addr_t'(idx);
    endfunction

    // n-th pixel of visible line y in the given frame
    function automatic color_t expected_pixel(input int frame, input int y, input int n);
        addr_t  base;
        addr_t  addr;
        word_t  word;
        color_t raw;
        base = cfg_addr[frame] + addr_t'(y) * cfg_len[frame];
        if (cfg_gfx[frame][7]) begin
            return cfg_border[frame];
        end
        if (cfg_gfx[frame][4]) begin
            addr = base + addr_t'(n / 2);
            word = pattern[addr[5:0]];
            raw  = (n % 2 == 0) ? word[15:8] : word[7:0];   // high byte first
        end else begin
            addr = base + addr_t'(n / 4);
            word = pattern[addr[5:0]];
            raw  = {4'h0, word[15 - 4 * (n % 4) -: 4]};     // high nibble first
        end
        return raw ^ cfg_gfx[frame][15:8];
    endfunction

    task automatic write_reg(input logic [4:0] num, input word_t data);
        reg_wr_en_i <= 1'b1;
        reg_num_i   <= num;
        reg_data_i  <= data;
        @(posedge clk);
        reg_wr_en_i <= 1'b0;
    endtask

    task automatic read_expect(input logic [4:0] num, input word_t expected, input string name);
        reg_wr_en_i <= 1'b0;
        reg_num_i   <= num;
        @(posedge clk);                             // readback flop loads here
        @(negedge clk);
        check_value(name, expected, reg_data_o);
        @(posedge clk);
    endtask

    // output monitor, frames are delimited by the vsync rise
    always @(negedge clk) begin
        if (reset_i) begin
            fr = 0;
            line_cnt = 0;
            px_cnt = 0;
            rd_cnt = 0;
            hs_cnt = 0;
            vs_len = 0;
            cyc_cnt = 0;
            sel_cnt = 0;
            prev_de = 1'b0;
            prev_hs = 1'b0;
            prev_vs = 1'b0;
        end else begin
            cyc_cnt = cyc_cnt + 1;
            if (vram_sel_o) begin
                sel_cnt = sel_cnt + 1;
                check_value("vram_addr_o", line_word_addr(fr, line_cnt, rd_cnt), vram_addr_o);
                rd_cnt = rd_cnt + 1;
            end
            if (hsync_o && !prev_hs) hs_cnt = hs_cnt + 1;
            if (vsync_o) vs_len = vs_len + 1;
            if (dv_de_o) begin
                check_value("color_index_o", expected_pixel(fr, line_cnt, px_cnt), color_index_o);
                px_cnt = px_cnt + 1;
            end else if (prev_de) begin
                check_value("dv_de_o cycles per line", H_VISIBLE, px_cnt);
                line_cnt = line_cnt + 1;
                px_cnt = 0;
                rd_cnt = 0;
            end
            if (!vsync_o && prev_vs) begin
                check_value("vsync_o pulse length", (V_SYNC_END - V_SYNC_START) * H_TOTAL, vs_len);
                vs_len = 0;
            end
            if (vsync_o && !prev_vs) begin
                check_value("dv_de_o lines per frame", V_VISIBLE, line_cnt);
                if (cfg_gfx[fr][7]) begin
                    check_value("vram_sel_o in blank frame", 0, sel_cnt);
                end
                if (fr > 0) begin                   // first frame starts at reset
                    check_value("hsync_o pulses per frame", V_TOTAL, hs_cnt);
                    check_value("cycles between vsync_o pulses", V_TOTAL * H_TOTAL, cyc_cnt);
                end
                fr = fr + 1;
                line_cnt = 0;
                hs_cnt = 0;
                cyc_cnt = 0;
                sel_cnt = 0;
            end
            prev_de = dv_de_o;
            prev_hs = hsync_o;
            prev_vs = vsync_o;
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: not all frames were seen within %0d time units", TIMEOUT);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        word_t      rnd;
        word_t      gfx;
        color_t     border;
        logic [4:0] unused_num;
        reset_i     = 1'b1;
        reg_wr_en_i = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        vram_data_i = '0;
        lfsr_state  = 17'd68547;
        $readmemh("tb/video_patterns.hex", pattern);
        cfg_gfx[0]    = 16'h0080;                   // reset state is blank
        cfg_border[0] = 8'h08;
        cfg_addr[0]   = '0;
        cfg_len[0]    = 16'(H_VISIBLE / 4);

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("dv_de_o in reset", 0, dv_de_o);
        check_value("hsync_o in reset", 0, hsync_o);
        check_value("vsync_o in reset", 0, vsync_o);
        check_value("color_index_o in reset", 0, color_index_o);
        check_value("vram_sel_o in reset", 0, vram_sel_o);
        @(posedge clk);
        reset_i <= 1'b0;

        for (int t = 0; t < NUM_TRIPLES; t++) begin
            while (fr != t + 1) @(posedge clk);     // vertical blanking after frame t
            read_expect(XR_SCANLINE, {1'b1, 5'b00000, vres_t'(V_SYNC_START)},
                        "reg_data_o scanline in blanking");
            take_random(8, rnd);
            border = rnd[7:0];
            take_random(8, rnd);
            gfx = {rnd[7:0], pattern[VRAM_WORDS + 3 * t][7:0]};
            write_reg(XR_VID_CTRL, {border, 8'h5a});    // low byte is unused
            write_reg(XR_PA_GFX_CTRL, gfx);
            write_reg(XR_PA_DISP_ADDR, pattern[VRAM_WORDS + 3 * t + 1]);
            write_reg(XR_PA_LINE_LEN, pattern[VRAM_WORDS + 3 * t + 2]);
            cfg_border[t + 1] = border;
            cfg_gfx[t + 1]    = gfx;
            cfg_addr[t + 1]   = pattern[VRAM_WORDS + 3 * t + 1];
            cfg_len[t + 1]    = pattern[VRAM_WORDS + 3 * t + 2];

            read_expect(XR_VID_CTRL, {border, 8'h00}, "reg_data_o vid_ctrl");
            read_expect(XR_PA_GFX_CTRL, gfx & 16'hff90, "reg_data_o gfx_ctrl");
            read_expect(XR_PA_DISP_ADDR, cfg_addr[t + 1], "reg_data_o disp_addr");
            read_expect(XR_PA_LINE_LEN, cfg_len[t + 1], "reg_data_o line_len");
            read_expect(XR_VID_HSIZE, 16'(H_VISIBLE), "reg_data_o hsize");
            read_expect(XR_VID_VSIZE, 16'(V_VISIBLE), "reg_data_o vsize");
            unused_num = XR_VID_CTRL;
            while (is_mapped(unused_num)) begin
                take_random(5, rnd);
                unused_num = rnd[4:0];
            end
            read_expect(unused_num, 16'h0000, "reg_data_o unused register");

            @(negedge clk);
            while (!dv_de_o) @(negedge clk);        // first visible line of the new frame
            @(posedge clk);
            read_expect(XR_SCANLINE, 16'h0000, "reg_data_o scanline in visible line");
        end

        while (fr != NUM_FRAMES) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/pixel_fetch.sv
rtl/pixel_shifter.sv
rtl/video_gen.sv
tb/tb_video_gen.sv

//--- Makefile
# Verilator build and run for the video generator testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_video_gen
FILELIST := sources.f
MDIR     := obj_dir
BIN      := $(MDIR)/V$(TOP)
LOG      := sim.log
PATTERNS := tb/video_patterns.hex
PASS_MSG := Test completed successfully
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN) $(PATTERNS)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)

//--- tb/video_patterns.hex
// words 0x00..0x3f: vram image, 8 words per line, lowest address first
// then one line per frame: gfx_ctrl disp_addr line_len (gfx_ctrl[15:8] is replaced)
0870 0961 0a52 0b43 0c34 0d25 0e16 0f07
1871 1962 1a53 1b44 1c35 1d26 1e17 1f08
2872 2963 2a54 2b45 2c36 2d27 2e18 2f09
3873 3964 3a55 3b46 3c37 3d28 3e19 3f0a
4874 4965 4a56 4b47 4c38 4d29 4e1a 4f0b
5875 5966 5a57 5b48 5c39 5d2a 5e1b 5f0c
6876 6967 6a58 6b49 6c3a 6d2b 6e1c 6f0d
7877 7968 7a59 7b4a 7c3b 7d2c 7e1d 7f0e
// frame 1: 4 bpp, frame 2: 8 bpp, frame 3: blank, frame 4: 8 bpp odd start
0000 0000 0004
0010 0010 0008
0080 0020 0004
0010 0021 0006
